// File: Makefile
VERILATOR  ?= verilator
TOP        := fetch_tb
FILELIST   := files.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
src/fetch_pkg.sv
src/axil_prog_loader.sv
src/instr_mem.sv
src/instruction_fetch.sv
src/instr_decode.sv
src/fetch_top.sv
test/tb_clk_gen.sv
test/fetch_tb.sv

// File: src/axil_prog_loader.sv
`timescale 1ns/1ns

module axil_prog_loader #(
    parameter int DEPTH = 64
) (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic [fetch_pkg::AXIL_ADDR_W-1:0]  i_s_axil_awaddr,
    input  logic                               i_s_axil_awvalid,
    output logic                               o_s_axil_awready,
    input  logic [fetch_pkg::XLEN-1:0]         i_s_axil_wdata,
    input  logic [fetch_pkg::AXIL_STRB_W-1:0]  i_s_axil_wstrb,
    input  logic                               i_s_axil_wvalid,
    output logic                               o_s_axil_wready,
    output logic [1:0]                         o_s_axil_bresp,
    output logic                               o_s_axil_bvalid,
    input  logic                               i_s_axil_bready,
    input  logic [fetch_pkg::AXIL_ADDR_W-1:0]  i_s_axil_araddr,
    input  logic                               i_s_axil_arvalid,
    output logic                               o_s_axil_arready,
    output logic [fetch_pkg::XLEN-1:0]         o_s_axil_rdata,
    output logic [1:0]                         o_s_axil_rresp,
    output logic                               o_s_axil_rvalid,
    input  logic                               i_s_axil_rready,
    output logic                               o_mem_we,
    output logic [$clog2(DEPTH)-1:0]           o_mem_waddr,
    output logic [fetch_pkg::XLEN-1:0]         o_mem_wdata,
    output logic [$clog2(DEPTH)-1:0]           o_mem_raddr,
    input  logic [fetch_pkg::XLEN-1:0]         i_mem_rdata,
    output logic                               o_run
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam logic [fetch_pkg::AXIL_ADDR_W-1:0] CTRL_ADDR =
        fetch_pkg::AXIL_ADDR_W'(4 * DEPTH);

    typedef enum logic [1:0] {W_IDLE, W_ACCEPT, W_RESP} wr_state_e;
    typedef enum logic [1:0] {R_IDLE, R_ACCEPT, R_DATA} rd_state_e;

    wr_state_e                 wr_state;
    rd_state_e                 rd_state;
    logic                      run;
    logic                      wr_is_mem;
    logic                      wr_is_ctrl;
    logic                      wr_mem_ok;
    logic                      rd_is_mem;
    logic                      rd_is_ctrl;
    logic [fetch_pkg::XLEN-1:0] ctrl_word;
    fetch_pkg::axi_resp_e      bresp_q;
    fetch_pkg::axi_resp_e      rresp_q;
    logic [fetch_pkg::XLEN-1:0] rdata_q;

    // Address decode, memory words must be aligned
    assign wr_is_mem  = (i_s_axil_awaddr < CTRL_ADDR) && (i_s_axil_awaddr[1:0] == 2'b00);
    assign wr_is_ctrl = (i_s_axil_awaddr == CTRL_ADDR);
    assign rd_is_mem  = (i_s_axil_araddr < CTRL_ADDR) && (i_s_axil_araddr[1:0] == 2'b00);
    assign rd_is_ctrl = (i_s_axil_araddr == CTRL_ADDR);

    // Full-word writes only, and never while the core runs
    assign wr_mem_ok = wr_is_mem && (&i_s_axil_wstrb) && !run;

    always_comb begin
        ctrl_word = '0;
        ctrl_word[fetch_pkg::CTRL_RUN_BIT] = run;
    end

    // Write channel: AW and W are taken together
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_state <= W_IDLE;
            run <= 1'b0;
        end else begin
            case (wr_state)
                W_IDLE: begin
                    if (i_s_axil_awvalid && i_s_axil_wvalid) begin
                        wr_state <= W_ACCEPT;
                    end
                end
                W_ACCEPT: begin
                    wr_state <= W_RESP;
                    if (wr_is_ctrl && i_s_axil_wstrb[0]) begin
                        run <= i_s_axil_wdata[fetch_pkg::CTRL_RUN_BIT];
                    end
                end
                W_RESP: begin
                    if (i_s_axil_bready) begin
                        wr_state <= W_IDLE;
                    end
                end
                default: wr_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_state == W_ACCEPT) begin
            bresp_q <= (wr_mem_ok || wr_is_ctrl) ? fetch_pkg::OKAY : fetch_pkg::SLVERR;
        end
    end

    // Read channel
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            rd_state <= R_IDLE;
        end else begin
            case (rd_state)
                R_IDLE: begin
                    if (i_s_axil_arvalid) begin
                        rd_state <= R_ACCEPT;
                    end
                end
                R_ACCEPT: rd_state <= R_DATA;
                R_DATA: begin
                    if (i_s_axil_rready) begin
                        rd_state <= R_IDLE;
                    end
                end
                default: rd_state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_state == R_ACCEPT) begin
            if (rd_is_mem) begin
                rdata_q <= i_mem_rdata;
                rresp_q <= fetch_pkg::OKAY;
            end else if (rd_is_ctrl) begin
                rdata_q <= ctrl_word;
                rresp_q <= fetch_pkg::OKAY;
            end else begin
                rdata_q <= '0;
                rresp_q <= fetch_pkg::SLVERR;
            end
        end
    end

    assign o_s_axil_awready = (wr_state == W_ACCEPT);
    assign o_s_axil_wready  = (wr_state == W_ACCEPT);
    assign o_s_axil_bvalid  = (wr_state == W_RESP);
    assign o_s_axil_bresp   = bresp_q;
    assign o_s_axil_arready = (rd_state == R_ACCEPT);
    assign o_s_axil_rvalid  = (rd_state == R_DATA);
    assign o_s_axil_rdata   = rdata_q;
    assign o_s_axil_rresp   = rresp_q;

    // Memory side
    assign o_mem_we    = (wr_state == W_ACCEPT) && wr_mem_ok;
    assign o_mem_waddr = i_s_axil_awaddr[ADDR_W+1:2];
    assign o_mem_wdata = i_s_axil_wdata;
    assign o_mem_raddr = i_s_axil_araddr[ADDR_W+1:2];
    assign o_run       = run;

endmodule

// File: src/fetch_pkg.sv
package fetch_pkg;

    // Instruction and data width
    localparam int XLEN = 32;

    // Instruction field widths
    localparam int OP_W = 6;
    localparam int REG_W = 5;
    localparam int IMM_W = 16;
    localparam int JT_W = 26;

    // AXI4-Lite host port
    localparam int AXIL_ADDR_W = 16;
    localparam int AXIL_STRB_W = XLEN / 8;

    // Run bit position in the control register
    localparam int CTRL_RUN_BIT = 0;

    // Major opcodes, ILLEGAL marks anything not listed
    typedef enum logic [OP_W-1:0] {
        ALU     = 6'd0,
        JUMP    = 6'd2,
        BEQ     = 6'd4,
        ADDI    = 6'd8,
        LOAD    = 6'd35,
        STORE   = 6'd43,
        ILLEGAL = 6'd63
    } opcode_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // One decoded instruction as it leaves the decode stage
    typedef struct packed {
        logic [XLEN-1:0]  pc;
        opcode_e          op;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  imm;
        logic [JT_W-1:0]  jtarget;
        logic             illegal;
    } decoded_t;

endpackage

// File: src/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
    parameter int DEPTH = 64
) (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic [fetch_pkg::AXIL_ADDR_W-1:0]  i_s_axil_awaddr,
    input  logic                               i_s_axil_awvalid,
    output logic                               o_s_axil_awready,
    input  logic [fetch_pkg::XLEN-1:0]         i_s_axil_wdata,
    input  logic [fetch_pkg::AXIL_STRB_W-1:0]  i_s_axil_wstrb,
    input  logic                               i_s_axil_wvalid,
    output logic                               o_s_axil_wready,
    output logic [1:0]                         o_s_axil_bresp,
    output logic                               o_s_axil_bvalid,
    input  logic                               i_s_axil_bready,
    input  logic [fetch_pkg::AXIL_ADDR_W-1:0]  i_s_axil_araddr,
    input  logic                               i_s_axil_arvalid,
    output logic                               o_s_axil_arready,
    output logic [fetch_pkg::XLEN-1:0]         o_s_axil_rdata,
    output logic [1:0]                         o_s_axil_rresp,
    output logic                               o_s_axil_rvalid,
    input  logic                               i_s_axil_rready,
    input  logic                               i_redirect_valid,
    input  logic [fetch_pkg::XLEN-1:0]         i_redirect_pc,
    output logic                               o_dec_valid,
    output fetch_pkg::decoded_t                o_dec,
    input  logic                               i_dec_ready
);

    localparam int ADDR_W = $clog2(DEPTH);

    logic                       mem_we;
    logic [ADDR_W-1:0]          mem_waddr;
    logic [fetch_pkg::XLEN-1:0] mem_wdata;
    logic [ADDR_W-1:0]          mem_raddr;
    logic [fetch_pkg::XLEN-1:0] mem_rdata;
    logic                       run;
    logic [ADDR_W-1:0]          fetch_addr;
    logic [fetch_pkg::XLEN-1:0] fetch_data;
    logic                       fetch_valid;
    logic [fetch_pkg::XLEN-1:0] fetch_pc;
    logic [fetch_pkg::XLEN-1:0] fetch_instr;
    logic                       dec_stall;

    axil_prog_loader #(.DEPTH(DEPTH)) u_loader (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_s_axil_awaddr(i_s_axil_awaddr), .i_s_axil_awvalid(i_s_axil_awvalid),
        .o_s_axil_awready(o_s_axil_awready),
        .i_s_axil_wdata(i_s_axil_wdata), .i_s_axil_wstrb(i_s_axil_wstrb),
        .i_s_axil_wvalid(i_s_axil_wvalid), .o_s_axil_wready(o_s_axil_wready),
        .o_s_axil_bresp(o_s_axil_bresp), .o_s_axil_bvalid(o_s_axil_bvalid),
        .i_s_axil_bready(i_s_axil_bready),
        .i_s_axil_araddr(i_s_axil_araddr), .i_s_axil_arvalid(i_s_axil_arvalid),
        .o_s_axil_arready(o_s_axil_arready),
        .o_s_axil_rdata(o_s_axil_rdata), .o_s_axil_rresp(o_s_axil_rresp),
        .o_s_axil_rvalid(o_s_axil_rvalid), .i_s_axil_rready(i_s_axil_rready),
        .o_mem_we(mem_we), .o_mem_waddr(mem_waddr), .o_mem_wdata(mem_wdata),
        .o_mem_raddr(mem_raddr), .i_mem_rdata(mem_rdata), .o_run(run)
    );

    instr_mem #(.DEPTH(DEPTH)) u_mem (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_we(mem_we), .i_waddr(mem_waddr), .i_wdata(mem_wdata),
        .i_host_raddr(mem_raddr), .o_host_rdata(mem_rdata),
        .i_fetch_addr(fetch_addr), .o_fetch_data(fetch_data)
    );

    instruction_fetch #(.DEPTH(DEPTH)) u_fetch (
        .i_clk(i_clk), .i_rst(i_rst), .i_run(run), .i_stall(dec_stall),
        .i_redirect_valid(i_redirect_valid), .i_redirect_pc(i_redirect_pc),
        .o_fetch_addr(fetch_addr), .i_fetch_data(fetch_data),
        .o_valid(fetch_valid), .o_pc(fetch_pc), .o_instr(fetch_instr)
    );

    // Redirect flushes the word held in decode
    instr_decode u_decode (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_valid(fetch_valid), .i_pc(fetch_pc), .i_instr(fetch_instr),
        .i_flush(i_redirect_valid), .o_stall(dec_stall),
        .o_dec_valid(o_dec_valid), .o_dec(o_dec), .i_dec_ready(i_dec_ready)
    );

endmodule

// File: src/instr_decode.sv
`timescale 1ns/1ns

module instr_decode (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_valid,
    input  logic [fetch_pkg::XLEN-1:0]  i_pc,
    input  logic [fetch_pkg::XLEN-1:0]  i_instr,
    input  logic                        i_flush,
    output logic                        o_stall,
    output logic                        o_dec_valid,
    output fetch_pkg::decoded_t         o_dec,
    input  logic                        i_dec_ready
);

    localparam int XLEN  = fetch_pkg::XLEN;
    localparam int OP_W  = fetch_pkg::OP_W;
    localparam int REG_W = fetch_pkg::REG_W;
    localparam int IMM_W = fetch_pkg::IMM_W;
    localparam int JT_W  = fetch_pkg::JT_W;

    logic [OP_W-1:0]     raw_op;
    logic                capture;
    logic                valid_q;
    fetch_pkg::decoded_t dec_d;
    fetch_pkg::decoded_t dec_q;

    assign raw_op = i_instr[XLEN-1 -: OP_W];

    // Field split, I-type immediate is sign extended
    always_comb begin
        dec_d.pc      = i_pc;
        dec_d.rs      = i_instr[XLEN-OP_W-1 -: REG_W];
        dec_d.rt      = i_instr[XLEN-OP_W-REG_W-1 -: REG_W];
        dec_d.rd      = i_instr[IMM_W-1 -: REG_W];
        dec_d.imm     = {{(XLEN-IMM_W){i_instr[IMM_W-1]}}, i_instr[IMM_W-1:0]};
        dec_d.jtarget = i_instr[JT_W-1:0];
        dec_d.illegal = 1'b0;
        case (raw_op)
            6'd0:    dec_d.op = fetch_pkg::ALU;
            6'd2:    dec_d.op = fetch_pkg::JUMP;
            6'd4:    dec_d.op = fetch_pkg::BEQ;
            6'd8:    dec_d.op = fetch_pkg::ADDI;
            6'd35:   dec_d.op = fetch_pkg::LOAD;
            6'd43:   dec_d.op = fetch_pkg::STORE;
            default: begin
                dec_d.op = fetch_pkg::ILLEGAL;
                dec_d.illegal = 1'b1;
            end
        endcase
    end

    // Take a new word when empty or when the held one is leaving
    assign capture = i_valid && (!valid_q || i_dec_ready);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else if (i_flush || !i_valid) begin
            // Wrong-path item or halted core, drop whatever is held
            valid_q <= 1'b0;
        end else if (capture) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (capture) begin
            dec_q <= dec_d;
        end
    end

    assign o_stall     = valid_q && !i_dec_ready;
    assign o_dec_valid = valid_q;
    assign o_dec       = dec_q;

endmodule

// File: src/instr_mem.sv
`timescale 1ns/1ns

module instr_mem #(
    parameter int DEPTH = 64
) (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_we,
    input  logic [$clog2(DEPTH)-1:0]    i_waddr,
    input  logic [fetch_pkg::XLEN-1:0]  i_wdata,
    input  logic [$clog2(DEPTH)-1:0]    i_host_raddr,
    output logic [fetch_pkg::XLEN-1:0]  o_host_rdata,
    input  logic [$clog2(DEPTH)-1:0]    i_fetch_addr,
    output logic [fetch_pkg::XLEN-1:0]  o_fetch_data
);

    logic [fetch_pkg::XLEN-1:0] mem [DEPTH];

    // Program store starts out all zero
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Host read-back and fetch both see the array directly
    assign o_host_rdata = mem[i_host_raddr];
    assign o_fetch_data = mem[i_fetch_addr];

endmodule

// File: src/instruction_fetch.sv
`timescale 1ns/1ns

module instruction_fetch #(
    parameter int DEPTH = 64
) (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_run,
    input  logic                        i_stall,
    input  logic                        i_redirect_valid,
    input  logic [fetch_pkg::XLEN-1:0]  i_redirect_pc,
    output logic [$clog2(DEPTH)-1:0]    o_fetch_addr,
    input  logic [fetch_pkg::XLEN-1:0]  i_fetch_data,
    output logic                        o_valid,
    output logic [fetch_pkg::XLEN-1:0]  o_pc,
    output logic [fetch_pkg::XLEN-1:0]  o_instr
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam logic [ADDR_W-1:0] LAST_PC = ADDR_W'(DEPTH - 1);

    logic [ADDR_W-1:0]          pc;
    logic [ADDR_W-1:0]          pc_cur;
    logic [ADDR_W-1:0]          pc_inc;
    logic [ADDR_W-1:0]          redir_idx;
    logic [fetch_pkg::XLEN-1:0] redir_mod;
    logic                       run_q;
    logic                       run_rise;

    // First cycle of a run always fetches word 0
    assign run_rise = i_run && !run_q;
    assign pc_cur   = run_rise ? '0 : pc;

    // Sequential successor, wrapping at the end of memory
    assign pc_inc = (pc_cur == LAST_PC) ? '0 : pc_cur + 1'b1;

    // Branch targets are word indices folded into the memory range
    assign redir_mod = i_redirect_pc % fetch_pkg::XLEN'(DEPTH);
    assign redir_idx = redir_mod[ADDR_W-1:0];

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            pc <= '0;
            run_q <= 1'b0;
        end else begin
            run_q <= i_run;
            if (i_redirect_valid) begin
                // Redirect wins over a stall
                pc <= redir_idx;
            end else if (i_run && !i_stall) begin
                pc <= pc_inc;
            end
        end
    end

    assign o_fetch_addr = pc_cur;
    assign o_valid      = i_run;
    assign o_pc         = fetch_pkg::XLEN'(pc_cur);
    assign o_instr      = i_fetch_data;

endmodule

// File: test/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;

    localparam int DEPTH = 64;
    localparam int CLK_NS = 4;
    localparam logic [31:0] SEED = 32'h2f71_7669;
    localparam int STREAM_CYCLES = 600;
    localparam int REDIR_CYCLES = 800;
    localparam int STOP_CYCLES = 50;
    localparam int RESTART_CYCLES = 400;
    // Run cycles budget covers all stream phases, each AXI transfer takes about 6 cycles
    localparam int RUN_CYCLES = 2000;
    localparam int TIMEOUT_NS = 2 * (4 * DEPTH * 6 + RUN_CYCLES) * CLK_NS;
    localparam logic [15:0] CTRL_ADDR = 16'(4 * DEPTH);

    logic                clk;
    logic                rst;
    logic [15:0]         awaddr;
    logic                awvalid;
    logic                awready;
    logic [31:0]         wdata;
    logic [3:0]          wstrb;
    logic                wvalid;
    logic                wready;
    logic [1:0]          bresp;
    logic                bvalid;
    logic                bready;
    logic [15:0]         araddr;
    logic                arvalid;
    logic                arready;
    logic [31:0]         rdata;
    logic [1:0]          rresp;
    logic                rvalid;
    logic                rready;
    logic                redirect_valid;
    logic [31:0]         redirect_pc;
    logic                dec_valid;
    fetch_pkg::decoded_t dec;
    logic                dec_ready;

    logic [31:0] model_mem [DEPTH];
    int          model_pc;
    int          first_pc;
    int          accepted;
    int          redirects;
    int          illegal_seen;
    int          legal_seen;
    int          err_count;
    int          test_err_start;
    int          tests_passed;
    int          tests_failed;

    tb_clk_gen #(.PERIOD_NS(CLK_NS)) u_clk_gen (.o_clk(clk));

    fetch_top #(.DEPTH(DEPTH)) u_dut (
        .i_clk(clk), .i_rst(rst),
        .i_s_axil_awaddr(awaddr), .i_s_axil_awvalid(awvalid), .o_s_axil_awready(awready),
        .i_s_axil_wdata(wdata), .i_s_axil_wstrb(wstrb), .i_s_axil_wvalid(wvalid),
        .o_s_axil_wready(wready), .o_s_axil_bresp(bresp), .o_s_axil_bvalid(bvalid),
        .i_s_axil_bready(bready), .i_s_axil_araddr(araddr), .i_s_axil_arvalid(arvalid),
        .o_s_axil_arready(arready), .o_s_axil_rdata(rdata), .o_s_axil_rresp(rresp),
        .o_s_axil_rvalid(rvalid), .i_s_axil_rready(rready),
        .i_redirect_valid(redirect_valid), .i_redirect_pc(redirect_pc),
        .o_dec_valid(dec_valid), .o_dec(dec), .i_dec_ready(dec_ready)
    );

    task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        if (got !== exp) begin
            err_count++;
            $display("ERR @%0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic report_problem(input string what);
        err_count++;
        $display("Problem at %0t ns: %s", $time, what);
    endtask

    task automatic close_test(input string name);
        if (err_count == test_err_start) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, err_count - test_err_start);
        end
        test_err_start = err_count;
    endtask

    function automatic bit opcode_known(input logic [5:0] code);
        return (code == 6'd0) || (code == 6'd2) || (code == 6'd4) ||
               (code == 6'd8) || (code == 6'd35) || (code == 6'd43);
    endfunction

    // Expected decode built from the instruction field layout
    function automatic fetch_pkg::decoded_t model_decode(input int pc, input logic [31:0] w);
        fetch_pkg::decoded_t d;
        d.pc      = 32'(pc);
        d.rs      = w[25:21];
        d.rt      = w[20:16];
        d.rd      = w[15:11];
        d.imm     = {{16{w[15]}}, w[15:0]};
        d.jtarget = w[25:0];
        d.illegal = !opcode_known(w[31:26]);
        d.op      = d.illegal ? fetch_pkg::ILLEGAL : fetch_pkg::opcode_e'(w[31:26]);
        return d;
    endfunction

    // Two out of three words get a legal opcode
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = $urandom;
        case ($urandom_range(0, 8))
            0: w[31:26] = 6'd0;
            1: w[31:26] = 6'd2;
            2: w[31:26] = 6'd4;
            3: w[31:26] = 6'd8;
            4: w[31:26] = 6'd35;
            5: w[31:26] = 6'd43;
            default: w[31:26] = w[31:26];
        endcase
        return w;
    endfunction

    task automatic write_word(input logic [15:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        @(posedge clk);
        awaddr <= addr;
        wdata <= data;
        wstrb <= strb;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        bready <= 1'b1;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic read_word(input logic [15:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        rready <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // Random back-pressure and optional redirects, every accepted item checked at negedge
    task automatic run_stream(input int cycles, input bit allow_redirect);
        fetch_pkg::decoded_t exp;
        bit                  redir;
        logic [31:0]         target;
        for (int c = 0; c < cycles; c++) begin
            redir = allow_redirect && ($urandom_range(0, 15) == 0);
            target = $urandom;
            @(posedge clk);
            dec_ready <= ($urandom_range(0, 3) != 0);
            redirect_valid <= redir;
            redirect_pc <= target;
            @(negedge clk);
            if (dec_valid && dec_ready) begin
                exp = model_decode(model_pc, model_mem[model_pc]);
                check_equal(dec, exp, $sformatf("decoded item at pc %0d", model_pc));
                if (exp.illegal) illegal_seen++;
                else legal_seen++;
                if (first_pc < 0) first_pc = int'(dec.pc);
                model_pc = (model_pc + 1) % DEPTH;
                accepted++;
            end
            if (redir) begin
                model_pc = int'(target % DEPTH);
                redirects++;
            end
        end
        @(posedge clk);
        dec_ready <= 1'b0;
        redirect_valid <= 1'b0;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        int          idx;
        void'($urandom(SEED));
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        dec_ready = 1'b0;
        err_count = 0;
        test_err_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        illegal_seen = 0;
        legal_seen = 0;
        redirects = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Load and read back while halted
        @(negedge clk);
        check_equal({awready, wready, bvalid, arready, rvalid, dec_valid}, '0,
                    "outputs after reset");
        read_word(16'd0, data, resp);
        check_equal(data, 32'd0, "word 0 after reset");
        read_word(CTRL_ADDR, data, resp);
        check_equal(data, 32'd0, "control register after reset");
        for (int i = 0; i < DEPTH; i++) begin
            model_mem[i] = random_word();
            write_word(16'(4 * i), model_mem[i], 4'hF, resp);
            check_equal(resp, fetch_pkg::OKAY, $sformatf("write response word %0d", i));
        end
        for (int i = 0; i < DEPTH; i++) begin
            read_word(16'(4 * i), data, resp);
            check_equal(resp, fetch_pkg::OKAY, $sformatf("read response word %0d", i));
            check_equal(data, model_mem[i], $sformatf("read-back word %0d", i));
        end
        read_word(CTRL_ADDR + 16'd4, data, resp);
        check_equal(resp, fetch_pkg::SLVERR, "unmapped read response");
        write_word(CTRL_ADDR + 16'd8, 32'd1, 4'hF, resp);
        check_equal(resp, fetch_pkg::SLVERR, "unmapped write response");
        write_word(16'd12, ~model_mem[3], 4'h3, resp);
        check_equal(resp, fetch_pkg::SLVERR, "partial strobe write response");
        read_word(16'd12, data, resp);
        check_equal(data, model_mem[3], "word 3 after partial write");
        close_test("load_readback");

        // Memory is locked while the core runs
        write_word(CTRL_ADDR, 32'd1, 4'hF, resp);
        check_equal(resp, fetch_pkg::OKAY, "run set response");
        model_pc = 0;
        idx = $urandom_range(0, DEPTH - 1);
        write_word(16'(4 * idx), ~model_mem[idx], 4'hF, resp);
        check_equal(resp, fetch_pkg::SLVERR, "write while running");
        read_word(16'(4 * idx), data, resp);
        check_equal(data, model_mem[idx], "protected word read-back");
        close_test("write_protect");

        first_pc = -1;
        accepted = 0;
        run_stream(STREAM_CYCLES, 1'b0);
        check_equal(32'(first_pc), 32'd0, "first pc after run");
        if (accepted < DEPTH) report_problem("stream did not wrap around memory");
        close_test("sequential_stream");

        run_stream(REDIR_CYCLES, 1'b1);
        if (redirects == 0) report_problem("no redirect was issued");
        close_test("redirect");

        // Halt, expect silence, then restart from word 0
        write_word(CTRL_ADDR, 32'd0, 4'hF, resp);
        check_equal(resp, fetch_pkg::OKAY, "run clear response");
        for (int c = 0; c < STOP_CYCLES; c++) begin
            @(posedge clk);
            dec_ready <= 1'($urandom_range(0, 1));
            @(negedge clk);
            check_equal(dec_valid, 1'b0, "item while halted");
        end
        @(posedge clk);
        dec_ready <= 1'b0;
        read_word(CTRL_ADDR, data, resp);
        check_equal(data, 32'd0, "control register while halted");
        write_word(CTRL_ADDR, 32'd1, 4'hF, resp);
        check_equal(resp, fetch_pkg::OKAY, "run restart response");
        model_pc = 0;
        first_pc = -1;
        run_stream(RESTART_CYCLES, 1'b0);
        check_equal(32'(first_pc), 32'd0, "first pc after restart");
        close_test("stop_restart");

        if (illegal_seen == 0) report_problem("no illegal opcode reached the output");
        if (legal_seen == 0) report_problem("no legal opcode reached the output");
        close_test("decode_fields");

        $display("Tests: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic o_clk
);

    // Free-running clock, low for the first half period
    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

endmodule
